//--- src/mipsIsaPkg.sv
package mipsIsaPkg;

	localparam int DATA_W     = 32;
	localparam int ADDR_W     = 9;  // 512-byte memory
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;
	localparam int OP_W       = 6;  // Opcode and funct fields
	localparam int SHAMT_W    = 5;

	// Byte step between instructions
	localparam logic [ADDR_W-1:0] PC_STEP = 4;

	typedef enum logic [OP_W-1:0] {
		opRType = 6'h00,
		opAddi  = 6'h08,
		opAddiu = 6'h09,
		opSlti  = 6'h0a,
		opSltiu = 6'h0b,
		opAndi  = 6'h0c,
		opOri   = 6'h0d,
		opXori  = 6'h0e,
		opLui   = 6'h0f,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcodeE;

	// Kept R-type functions
	typedef enum logic [OP_W-1:0] {
		fnSll  = 6'h00,
		fnSrl  = 6'h02,
		fnSra  = 6'h03,
		fnSllv = 6'h04,
		fnSrlv = 6'h06,
		fnSrav = 6'h07,
		fnAdd  = 6'h20,
		fnAddu = 6'h21,
		fnSub  = 6'h22,
		fnSubu = 6'h23,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnXor  = 6'h26,
		fnNor  = 6'h27,
		fnSlt  = 6'h2a,
		fnSltu = 6'h2b
	} functE;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluNor,
		aluXor,
		aluSlt,
		aluSltu,
		aluSll,
		aluSrl,
		aluSra,
		aluLui
	} aluOpE;

endpackage

//--- src/mipsCtrlPkg.sv
package mipsCtrlPkg;

	typedef enum logic [3:0] {
		stIdle,
		stFetch,
		stFetchWait,
		stDecode,
		stExecute,
		stWriteBack,
		stMemAddr,
		stLoadWait,
		stLoadWrite,
		stStoreWait
	} stateE;

	typedef enum logic [1:0] {
		bSelReg,
		bSelSignImm,
		bSelZeroImm
	} aluBSelE;

	// Shift amount source
	typedef enum logic {
		shSa,   // Instruction sa field
		shReg   // Low bits of rs
	} shiftSelE;

	typedef enum logic {
		dstRd,
		dstRt
	} regDstSelE;

	typedef enum logic {
		inAlu,
		inMem
	} regInSelE;

	typedef enum logic {
		adrPc,
		adrAlu
	} addrSelE;

endpackage

//--- src/ctrlIf.sv
`timescale 1ns/10ps

interface ctrlIf;
	logic                     irLoad;
	logic                     pcLoad;
	logic                     marLoad;
	logic                     mdrLoad;
	logic                     regWrite;
	mipsIsaPkg::aluOpE        aluOp;
	mipsCtrlPkg::aluBSelE     aluBSel;
	mipsCtrlPkg::shiftSelE    shiftSel;
	mipsCtrlPkg::regDstSelE   regDstSel;
	mipsCtrlPkg::regInSelE    regInSel;
	mipsCtrlPkg::addrSelE     addrSel;

	// Raw fields, may hold codes outside the enums
	logic [mipsIsaPkg::OP_W-1:0] opcode;
	logic [mipsIsaPkg::OP_W-1:0] funct;

	modport ctrl (
		output irLoad, pcLoad, marLoad, mdrLoad, regWrite,
		output aluOp, aluBSel, shiftSel, regDstSel, regInSel, addrSel,
		input  opcode, funct
	);

	modport dp (
		input  irLoad, pcLoad, marLoad, mdrLoad, regWrite,
		input  aluOp, aluBSel, shiftSel, regDstSel, regInSel, addrSel,
		output opcode, funct
	);
endinterface

//--- src/alu.sv
`timescale 1ns/10ps

module alu (
	input  mipsIsaPkg::aluOpE                 aluOp,
	input  logic [mipsIsaPkg::DATA_W-1:0]     a,
	input  logic [mipsIsaPkg::DATA_W-1:0]     b,
	input  logic [mipsIsaPkg::SHAMT_W-1:0]    shamt,
	output logic [mipsIsaPkg::DATA_W-1:0]     result
);

	// Shifts act on b, which carries rt
	always_comb begin
		result = '0;
		case (aluOp)
			mipsIsaPkg::aluAdd: result = a + b;
			mipsIsaPkg::aluSub: result = a - b;
			mipsIsaPkg::aluAnd: result = a & b;
			mipsIsaPkg::aluOr:  result = a | b;
			mipsIsaPkg::aluNor: result = ~(a | b);
			mipsIsaPkg::aluXor: result = a ^ b;
			mipsIsaPkg::aluSlt: begin
				result[0] = $signed(a) < $signed(b);
			end
			mipsIsaPkg::aluSltu: begin
				result[0] = a < b;
			end
			mipsIsaPkg::aluSll: result = b << shamt;
			mipsIsaPkg::aluSrl: result = b >> shamt;
			mipsIsaPkg::aluSra: result = $signed(b) >>> shamt; // Sign bit fills in
			mipsIsaPkg::aluLui: result = {b[15:0], 16'h0000};
			default:            result = '0;
		endcase
	end

endmodule

//--- src/registerFile.sv
`timescale 1ns/10ps

module registerFile (
	input  logic                                CLK,
	input  logic                                reset,
	input  logic                                writeEn,
	input  logic [mipsIsaPkg::REG_ADDR_W-1:0]   writeAddr,
	input  logic [mipsIsaPkg::DATA_W-1:0]       writeData,
	input  logic [mipsIsaPkg::REG_ADDR_W-1:0]   readAddrA,
	input  logic [mipsIsaPkg::REG_ADDR_W-1:0]   readAddrB,
	output logic [mipsIsaPkg::DATA_W-1:0]       readDataA,
	output logic [mipsIsaPkg::DATA_W-1:0]       readDataB
);
	logic [mipsIsaPkg::DATA_W-1:0] regs [mipsIsaPkg::NUM_REGS];

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < mipsIsaPkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeAddr != '0) begin // r0 stays zero
			regs[writeAddr] <= writeData;
		end
	end

	assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

	knownWriteAddr: assert property (@(posedge CLK) disable iff (reset)
		writeEn |-> !$isunknown(writeAddr));

endmodule

//--- src/controlUnit.sv
`timescale 1ns/10ps

module controlUnit (
	input  logic  CLK,
	input  logic  reset,
	input  logic  memAck,
	output logic  memReq,
	output logic  memWrite,
	ctrlIf.ctrl   c
);
	mipsCtrlPkg::stateE state;
	mipsCtrlPkg::stateE nextState;

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= mipsCtrlPkg::stIdle;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			mipsCtrlPkg::stIdle:      nextState = mipsCtrlPkg::stFetch;
			mipsCtrlPkg::stFetch:     nextState = mipsCtrlPkg::stFetchWait;
			mipsCtrlPkg::stFetchWait: if (memAck) nextState = mipsCtrlPkg::stDecode;
			mipsCtrlPkg::stDecode: begin
				case (c.opcode)
					mipsIsaPkg::opRType, mipsIsaPkg::opAddi, mipsIsaPkg::opAddiu,
					mipsIsaPkg::opSlti, mipsIsaPkg::opSltiu, mipsIsaPkg::opAndi,
					mipsIsaPkg::opOri, mipsIsaPkg::opXori, mipsIsaPkg::opLui:
						nextState = mipsCtrlPkg::stExecute;
					mipsIsaPkg::opLw, mipsIsaPkg::opSw:
						nextState = mipsCtrlPkg::stMemAddr;
					default: nextState = mipsCtrlPkg::stFetch; // Unknown opcode is a no-op
				endcase
			end
			mipsCtrlPkg::stExecute:   nextState = mipsCtrlPkg::stWriteBack;
			mipsCtrlPkg::stWriteBack: nextState = mipsCtrlPkg::stFetch;
			mipsCtrlPkg::stMemAddr: begin
				if (c.opcode == mipsIsaPkg::opLw) begin
					nextState = mipsCtrlPkg::stLoadWait;
				end else begin
					nextState = mipsCtrlPkg::stStoreWait;
				end
			end
			mipsCtrlPkg::stLoadWait:  if (memAck) nextState = mipsCtrlPkg::stLoadWrite;
			mipsCtrlPkg::stLoadWrite: nextState = mipsCtrlPkg::stFetch;
			mipsCtrlPkg::stStoreWait: if (memAck) nextState = mipsCtrlPkg::stFetch;
			default:                  nextState = mipsCtrlPkg::stIdle;
		endcase
	end

	// Per-state enables and memory handshake
	always_comb begin
		c.irLoad   = 1'b0;
		c.pcLoad   = 1'b0;
		c.marLoad  = 1'b0;
		c.mdrLoad  = 1'b0;
		c.regWrite = 1'b0;
		c.regInSel = mipsCtrlPkg::inAlu;
		c.addrSel  = mipsCtrlPkg::adrPc;
		memReq     = 1'b0;
		memWrite   = 1'b0;
		case (state)
			mipsCtrlPkg::stFetch: c.marLoad = 1'b1; // MAR <= PC
			mipsCtrlPkg::stFetchWait: begin
				memReq   = 1'b1;
				c.irLoad = memAck;
				c.pcLoad = memAck;
			end
			mipsCtrlPkg::stWriteBack: c.regWrite = 1'b1;
			mipsCtrlPkg::stMemAddr: begin
				c.addrSel = mipsCtrlPkg::adrAlu;
				c.marLoad = 1'b1;
				c.mdrLoad = 1'b1;   // Captures rt for a store
			end
			mipsCtrlPkg::stLoadWait: begin
				memReq     = 1'b1;
				c.regInSel = mipsCtrlPkg::inMem;
				c.mdrLoad  = memAck;
			end
			mipsCtrlPkg::stLoadWrite: begin
				c.regInSel = mipsCtrlPkg::inMem;
				c.regWrite = 1'b1;
			end
			mipsCtrlPkg::stStoreWait: begin
				memReq   = 1'b1;
				memWrite = 1'b1;
			end
			default: ;
		endcase
	end

	// ALU operation and operand selects from opcode and funct
	always_comb begin
		c.aluOp     = mipsIsaPkg::aluAdd;
		c.aluBSel   = mipsCtrlPkg::bSelReg;
		c.shiftSel  = mipsCtrlPkg::shSa;
		c.regDstSel = mipsCtrlPkg::dstRt;
		case (c.opcode)
			mipsIsaPkg::opRType: begin
				c.regDstSel = mipsCtrlPkg::dstRd;
				case (c.funct)
					mipsIsaPkg::fnSub, mipsIsaPkg::fnSubu: c.aluOp = mipsIsaPkg::aluSub;
					mipsIsaPkg::fnAnd:  c.aluOp = mipsIsaPkg::aluAnd;
					mipsIsaPkg::fnOr:   c.aluOp = mipsIsaPkg::aluOr;
					mipsIsaPkg::fnNor:  c.aluOp = mipsIsaPkg::aluNor;
					mipsIsaPkg::fnXor:  c.aluOp = mipsIsaPkg::aluXor;
					mipsIsaPkg::fnSlt:  c.aluOp = mipsIsaPkg::aluSlt;
					mipsIsaPkg::fnSltu: c.aluOp = mipsIsaPkg::aluSltu;
					mipsIsaPkg::fnSll:  c.aluOp = mipsIsaPkg::aluSll;
					mipsIsaPkg::fnSrl:  c.aluOp = mipsIsaPkg::aluSrl;
					mipsIsaPkg::fnSra:  c.aluOp = mipsIsaPkg::aluSra;
					mipsIsaPkg::fnSllv: begin
						c.aluOp    = mipsIsaPkg::aluSll;
						c.shiftSel = mipsCtrlPkg::shReg;
					end
					mipsIsaPkg::fnSrlv: begin
						c.aluOp    = mipsIsaPkg::aluSrl;
						c.shiftSel = mipsCtrlPkg::shReg;
					end
					mipsIsaPkg::fnSrav: begin
						c.aluOp    = mipsIsaPkg::aluSra;
						c.shiftSel = mipsCtrlPkg::shReg;
					end
					default: c.aluOp = mipsIsaPkg::aluAdd; // ADD, ADDU
				endcase
			end
			mipsIsaPkg::opSlti: begin
				c.aluOp   = mipsIsaPkg::aluSlt;
				c.aluBSel = mipsCtrlPkg::bSelSignImm;
			end
			mipsIsaPkg::opSltiu: begin
				c.aluOp   = mipsIsaPkg::aluSltu;
				c.aluBSel = mipsCtrlPkg::bSelSignImm;
			end
			mipsIsaPkg::opAndi: begin
				c.aluOp   = mipsIsaPkg::aluAnd;
				c.aluBSel = mipsCtrlPkg::bSelZeroImm;
			end
			mipsIsaPkg::opOri: begin
				c.aluOp   = mipsIsaPkg::aluOr;
				c.aluBSel = mipsCtrlPkg::bSelZeroImm;
			end
			mipsIsaPkg::opXori: begin
				c.aluOp   = mipsIsaPkg::aluXor;
				c.aluBSel = mipsCtrlPkg::bSelZeroImm;
			end
			mipsIsaPkg::opLui: begin
				c.aluOp   = mipsIsaPkg::aluLui;
				c.aluBSel = mipsCtrlPkg::bSelZeroImm;
			end
			default: c.aluBSel = mipsCtrlPkg::bSelSignImm; // ADDI, ADDIU, LW, SW
		endcase
	end

	reqHeldUntilAck: assert property (@(posedge CLK) disable iff (reset)
		memReq && !memAck |=> memReq && $stable(memWrite));

	ackOnlyWithReq: assert property (@(posedge CLK) disable iff (reset)
		memAck |-> memReq);

	// Register writes only close an execute or a load sequence
	writeOnlyInWriteStates: assert property (@(posedge CLK) disable iff (reset)
		c.regWrite |-> state inside {mipsCtrlPkg::stWriteBack, mipsCtrlPkg::stLoadWrite}
			&& $past(state) inside {mipsCtrlPkg::stExecute, mipsCtrlPkg::stLoadWait});

endmodule

//--- src/datapath.sv
`timescale 1ns/10ps

module datapath (
	input  logic                            CLK,
	input  logic                            reset,
	input  logic [mipsIsaPkg::DATA_W-1:0]   memRData,
	output logic [mipsIsaPkg::ADDR_W-1:0]   memAddr,
	output logic [mipsIsaPkg::DATA_W-1:0]   memWData,
	ctrlIf.dp                               c
);
	logic [mipsIsaPkg::ADDR_W-1:0]     pc;
	logic [mipsIsaPkg::ADDR_W-1:0]     mar;
	logic [mipsIsaPkg::ADDR_W-1:0]     marIn;
	logic [mipsIsaPkg::DATA_W-1:0]     ir;
	logic [mipsIsaPkg::DATA_W-1:0]     mdr;
	logic [mipsIsaPkg::DATA_W-1:0]     mdrIn;
	logic [mipsIsaPkg::DATA_W-1:0]     aluOut;    // Result register
	logic [mipsIsaPkg::DATA_W-1:0]     aluResult;

	logic [mipsIsaPkg::REG_ADDR_W-1:0] rs;
	logic [mipsIsaPkg::REG_ADDR_W-1:0] rt;
	logic [mipsIsaPkg::REG_ADDR_W-1:0] rd;
	logic [mipsIsaPkg::REG_ADDR_W-1:0] wrAddr;
	logic [mipsIsaPkg::SHAMT_W-1:0]    sa;
	logic [mipsIsaPkg::SHAMT_W-1:0]    shamt;
	logic [15:0]                       imm;

	logic [mipsIsaPkg::DATA_W-1:0]     rfA;
	logic [mipsIsaPkg::DATA_W-1:0]     rfB;
	logic [mipsIsaPkg::DATA_W-1:0]     aluB;
	logic [mipsIsaPkg::DATA_W-1:0]     wrData;

	// Instruction fields
	assign c.opcode = ir[31:26];
	assign rs       = ir[25:21];
	assign rt       = ir[20:16];
	assign rd       = ir[15:11];
	assign sa       = ir[10:6];
	assign imm      = ir[15:0];
	assign c.funct  = ir[5:0];

	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= '0;
		end else if (c.pcLoad) begin
			pc <= pc + mipsIsaPkg::PC_STEP;
		end
	end

	always_ff @(posedge CLK) begin
		if (c.irLoad) ir <= memRData;
		if (c.marLoad) mar <= marIn;
		if (c.mdrLoad) mdr <= mdrIn;
		aluOut <= aluResult;
	end

	// MAR takes the ALU output directly so the address is ready for the wait state
	assign marIn = (c.addrSel == mipsCtrlPkg::adrAlu) ? aluResult[mipsIsaPkg::ADDR_W-1:0] : pc;

	// Data register holds store data, or the load word once acknowledged
	assign mdrIn = (c.regInSel == mipsCtrlPkg::inMem) ? memRData : rfB;

	always_comb begin
		case (c.aluBSel)
			mipsCtrlPkg::bSelSignImm: aluB = {{16{imm[15]}}, imm};
			mipsCtrlPkg::bSelZeroImm: aluB = {16'h0000, imm};
			default:                  aluB = rfB;
		endcase
	end

	assign shamt  = (c.shiftSel == mipsCtrlPkg::shReg) ? rfA[mipsIsaPkg::SHAMT_W-1:0] : sa;
	assign wrAddr = (c.regDstSel == mipsCtrlPkg::dstRd) ? rd : rt;
	assign wrData = (c.regInSel == mipsCtrlPkg::inMem) ? mdr : aluOut;

	registerFile u_regs (
		.CLK       (CLK),
		.reset     (reset),
		.writeEn   (c.regWrite),
		.writeAddr (wrAddr),
		.writeData (wrData),
		.readAddrA (rs),
		.readAddrB (rt),
		.readDataA (rfA),
		.readDataB (rfB)
	);

	alu u_alu (
		.aluOp  (c.aluOp),
		.a      (rfA),
		.b      (aluB),
		.shamt  (shamt),
		.result (aluResult)
	);

	assign memAddr  = mar;
	assign memWData = mdr;

endmodule

//--- src/mipsTop.sv
`timescale 1ns/10ps

module mipsTop (
	input  logic                            CLK,
	input  logic                            reset,
	output logic                            memReq,
	output logic                            memWrite,
	output logic [mipsIsaPkg::ADDR_W-1:0]   memAddr,
	output logic [mipsIsaPkg::DATA_W-1:0]   memWData,
	input  logic                            memAck,
	input  logic [mipsIsaPkg::DATA_W-1:0]   memRData
);

	ctrlIf ctrlBus ();

	// FSM side drives the handshake flags
	controlUnit u_ctrl (
		.CLK      (CLK),
		.reset    (reset),
		.memAck   (memAck),
		.memReq   (memReq),
		.memWrite (memWrite),
		.c        (ctrlBus.ctrl)
	);

	// Address and write data come from the datapath registers
	datapath u_dp (
		.CLK      (CLK),
		.reset    (reset),
		.memRData (memRData),
		.memAddr  (memAddr),
		.memWData (memWData),
		.c        (ctrlBus.dp)
	);

endmodule

//--- verification/mipsChecker.sv
`timescale 1ns/10ps

module mipsChecker (
	input  logic                          CLK,
	input  logic                          reset,
	input  logic                          memReq,
	input  logic                          memWrite,
	input  logic [mipsIsaPkg::ADDR_W-1:0] memAddr,
	input  logic [mipsIsaPkg::DATA_W-1:0] memWData,
	input  logic                          memAck,
	output int                            errCount
);
	logic [31:0] refMem [128];  // Initial image, filled by the bench
	logic [8:0]  expAddr [$];
	logic [31:0] expData [$];
	string       expName [$];
	logic        seenReq = 1'b0;
	int          errors = 0;
	string       curName;
	logic [8:0]  curAddr;
	logic [31:0] curData;

	assign errCount = errors;

	// Instruction model, queues every store it expects
	function automatic void runReference(input int nWords);
		logic [31:0] r [32];
		logic [31:0] m [128];
		string       src [32];  // Kind of instruction that last wrote each register
		string       tag;
		string       name;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] imSx;
		logic [31:0] ea;
		logic [4:0]  dst;
		logic        wr;
		tag = "";
		for (int i = 0; i < 32; i++) begin
			r[i]   = '0;
			src[i] = "zeroReg";
		end
		for (int i = 0; i < 128; i++) m[i] = refMem[i];
		for (int pc = 0; pc < nWords; pc++) begin
			ins  = m[pc];
			a    = r[ins[25:21]];
			b    = r[ins[20:16]];
			imSx = {{16{ins[15]}}, ins[15:0]};
			ea   = a + imSx;
			dst  = ins[20:16];
			wr   = 1'b1;
			res  = '0;
			name = "immediate";
			case (ins[31:26])
				6'h00: begin
					dst  = ins[15:11];
					name = (ins[5:3] == 3'b000) ? "shift" : "rtype";
					case (ins[5:0])
						6'h00: res = b << ins[10:6];
						6'h02: res = b >> ins[10:6];
						6'h03: res = $signed(b) >>> ins[10:6];
						6'h04: res = b << a[4:0];
						6'h06: res = b >> a[4:0];
						6'h07: res = $signed(b) >>> a[4:0];
						6'h20, 6'h21: res = a + b;
						6'h22, 6'h23: res = a - b;
						6'h24: res = a & b;
						6'h25: res = a | b;
						6'h26: res = a ^ b;
						6'h27: res = ~(a | b);
						6'h2a: res = {31'b0, $signed(a) < $signed(b)};
						6'h2b: res = {31'b0, a < b};
						default: wr = 1'b0;
					endcase
				end
				6'h08, 6'h09: res = a + imSx;
				6'h0a: res = {31'b0, $signed(a) < $signed(imSx)};
				6'h0b: res = {31'b0, a < imSx};
				6'h0c: res = a & {16'h0000, ins[15:0]};
				6'h0d: res = a | {16'h0000, ins[15:0]};
				6'h0e: res = a ^ {16'h0000, ins[15:0]};
				6'h0f: res = {ins[15:0], 16'h0000};
				6'h23: begin
					res  = m[ea[8:2]];
					name = "load";
				end
				6'h2b: begin
					wr = 1'b0;
					expAddr.push_back(ea[8:0]);
					expData.push_back(b);
					if (tag != "") begin
						expName.push_back(tag);
					end else begin
						expName.push_back(src[ins[20:16]]);
					end
					tag = "";
					m[ea[8:2]] = b;
				end
				default: begin
					wr  = 1'b0;
					tag = "unknownOp";  // Next store shows nothing changed
				end
			endcase
			if (wr && dst != 5'd0) begin
				r[dst]   = res;
				src[dst] = name;
			end
		end
	endfunction

	function automatic int reportMissing();
		if (expData.size() != 0) begin
			$display("%0d expected stores never arrived, next one was to address %h",
				expData.size(), expAddr[0]);
		end
		return expData.size();
	endfunction

	always @(posedge CLK) begin
		if (reset) begin
			if (memReq === 1'b1) begin
				$display("memReq was high during reset at %0t", $time);
				errors++;
			end
		end else begin
			if (memReq && !seenReq) begin
				seenReq = 1'b1;
				if ({memWrite, memAddr} !== 10'h000) begin  // Fetch of address 0
					$display("Error resetState: first request expected %h actual %h",
						10'h000, {memWrite, memAddr});
					errors++;
				end
			end
			if (memReq && memWrite && memAck) begin
				if (expData.size() == 0) begin
					$display("Unexpected extra store of %h to address %h", memWData, memAddr);
					errors++;
				end else begin
					curName = expName.pop_front();
					curAddr = expAddr.pop_front();
					curData = expData.pop_front();
					if (memAddr !== curAddr) begin
						$display("Error %s: store address expected %h actual %h",
							curName, curAddr, memAddr);
						errors++;
					end
					if (memWData !== curData) begin
						$display("Error %s: store data expected %h actual %h",
							curName, curData, memWData);
						errors++;
					end
				end
			end
		end
	end

endmodule

//--- verification/mipsTb.sv
`timescale 1ns/10ps

module mipsTb;
	localparam int MEM_WORDS = 128;
	localparam int DATA_WORD = 96;   // Data region at byte address 384
	localparam int PRELOAD   = 29;   // Data slots 29 to 31 hold preloaded words
	localparam int TIMEOUT   = 5000;

	logic                          CLK;
	logic                          reset;
	logic                          memReq;
	logic                          memWrite;
	logic [mipsIsaPkg::ADDR_W-1:0] memAddr;
	logic [mipsIsaPkg::DATA_W-1:0] memWData;
	logic                          memAck;
	logic [mipsIsaPkg::DATA_W-1:0] memRData;

	logic [31:0] mem [MEM_WORDS];
	logic [5:0]  rFuncts [16];
	logic [5:0]  immOps [8];
	integer      seed;
	int          progLen;
	int          storeSlot;
	int          delayLeft;
	int          benchErrors;
	int          checkErrors;
	int          missing;
	int          cycles;

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	mipsTop u_dut (
		.CLK      (CLK),
		.reset    (reset),
		.memReq   (memReq),
		.memWrite (memWrite),
		.memAddr  (memAddr),
		.memWData (memWData),
		.memAck   (memAck),
		.memRData (memRData)
	);

	mipsChecker u_check (
		.CLK      (CLK),
		.reset    (reset),
		.memReq   (memReq),
		.memWrite (memWrite),
		.memAddr  (memAddr),
		.memWData (memWData),
		.memAck   (memAck),
		.errCount (checkErrors)
	);

	function automatic logic [4:0] randReg();
		int v;
		v = $unsigned($random(seed)) % 15;
		return v[4:0] + 5'd1;
	endfunction

	function automatic logic [15:0] rand16();
		logic [31:0] v;
		v = $random(seed);
		return v[15:0];
	endfunction

	task automatic emit(input logic [31:0] word);
		mem[progLen] = word;
		progLen++;
	endtask

	task automatic storeReg(input logic [4:0] r);
		int byteAddr;
		byteAddr = (DATA_WORD + storeSlot) * 4;
		emit({mipsIsaPkg::opSw, 5'd0, r, byteAddr[15:0]});
		storeSlot++;
	endtask

	task automatic loadReg(input logic [4:0] r, input int slot);
		int byteAddr;
		byteAddr = (DATA_WORD + slot) * 4;
		emit({mipsIsaPkg::opLw, 5'd0, r, byteAddr[15:0]});
	endtask

	task automatic buildProgram();
		logic [4:0]  d;
		logic [4:0]  s;
		logic [4:0]  t;
		logic [15:0] v;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = 32'hfc00_0000 | i;  // Unknown opcode tagged with its index
		end
		for (int i = PRELOAD; i < 32; i++) begin
			mem[DATA_WORD + i] = $random(seed);
		end
		rFuncts = '{mipsIsaPkg::fnAdd, mipsIsaPkg::fnAddu, mipsIsaPkg::fnSub,
			mipsIsaPkg::fnSubu, mipsIsaPkg::fnAnd, mipsIsaPkg::fnOr, mipsIsaPkg::fnNor,
			mipsIsaPkg::fnXor, mipsIsaPkg::fnSlt, mipsIsaPkg::fnSltu, mipsIsaPkg::fnSll,
			mipsIsaPkg::fnSrl, mipsIsaPkg::fnSra, mipsIsaPkg::fnSllv, mipsIsaPkg::fnSrlv,
			mipsIsaPkg::fnSrav};
		immOps = '{mipsIsaPkg::opAddi, mipsIsaPkg::opAddiu, mipsIsaPkg::opSlti,
			mipsIsaPkg::opSltiu, mipsIsaPkg::opAndi, mipsIsaPkg::opOri,
			mipsIsaPkg::opXori, mipsIsaPkg::opLui};
		progLen   = 0;
		storeSlot = 0;
		d = 5'd1;
		repeat (15) begin  // Full random word in r1 to r15
			emit({mipsIsaPkg::opLui, 5'd0, d, rand16()});
			emit({mipsIsaPkg::opOri, d, d, rand16()});
			d++;
		end
		for (int k = 0; k < 16; k++) begin
			s = randReg();
			t = randReg();
			d = randReg();
			v = rand16();
			if (rFuncts[k] == mipsIsaPkg::fnSra || rFuncts[k] == mipsIsaPkg::fnSrav) begin
				if (t == s) t = s % 5'd15 + 5'd1;  // SRAV amount comes from another register
				emit({mipsIsaPkg::opLui, 5'd0, t, rand16() | 16'h8000});  // Negative rt
			end
			emit({6'h00, s, t, d, v[4:0], rFuncts[k]});
			storeReg(d);
		end
		for (int k = 0; k < 8; k++) begin
			s = randReg();
			d = randReg();
			emit({immOps[k], s, d, rand16() | 16'h8000});  // Top bit set so extension shows
			storeReg(d);
		end
		s = randReg();
		d = randReg();
		emit({6'h3e, s, d, rand16()});  // Not a kept opcode
		storeReg(d);
		emit({mipsIsaPkg::opAddi, randReg(), 5'd0, rand16()});
		storeReg(5'd0);
		d = randReg();
		loadReg(d, $unsigned($random(seed)) % storeSlot);
		storeReg(d);
		loadReg(d, PRELOAD + 1);
		storeReg(d);
		loadReg(d, PRELOAD + 2);
		storeReg(d);
	endtask

	// Memory model acks after 0 to 5 idle cycles
	always @(negedge CLK) begin
		if (memAck) begin
			memAck = 1'b0;
		end else if (!reset && memReq) begin
			if (delayLeft < 0) delayLeft = $unsigned($random(seed)) % 6;
			if (delayLeft == 0) begin
				memAck    = 1'b1;
				delayLeft = -1;
				if (memWrite) begin
					mem[memAddr[8:2]] = memWData;
				end else begin
					memRData = mem[memAddr[8:2]];
				end
			end else begin
				delayLeft--;
			end
		end
	end

	initial begin
		seed        = 32'h35722496;
		reset       = 1'b1;
		memAck      = 1'b0;
		memRData    = '0;
		delayLeft   = -1;
		benchErrors = 0;
		buildProgram();
		for (int i = 0; i < MEM_WORDS; i++) begin
			u_check.refMem[i] = mem[i];
		end
		u_check.runReference(progLen);
		repeat (5) @(negedge CLK);
		reset  = 1'b0;
		cycles = 0;
		// Run ends with the fetch just past the last instruction
		while (!(memReq && memAddr == progLen * 4) && cycles < TIMEOUT) begin
			@(negedge CLK);
			cycles++;
		end
		if (cycles >= TIMEOUT) begin
			$display("Timeout after %0d cycles waiting for the fetch past the program", TIMEOUT);
			benchErrors++;
		end
		missing = u_check.reportMissing();
		$display("Checker errors: %0d, missing stores: %0d, bench errors: %0d",
			checkErrors, missing, benchErrors);
		if (checkErrors + missing + benchErrors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- tb.f
src/mipsIsaPkg.sv
src/mipsCtrlPkg.sv
src/ctrlIf.sv
src/alu.sv
src/registerFile.sv
src/controlUnit.sv
src/datapath.sv
src/mipsTop.sv
verification/mipsChecker.sv
verification/mipsTb.sv

//--- Bender.yml
package:
  name: mips_multicycle

sources:
  - src/mipsIsaPkg.sv
  - src/mipsCtrlPkg.sv
  - src/ctrlIf.sv
  - src/alu.sv
  - src/registerFile.sv
  - src/controlUnit.sv
  - src/datapath.sv
  - src/mipsTop.sv
  - target: test
    files:
      - verification/mipsChecker.sv
      - verification/mipsTb.sv
